/* common/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath and address width
`define RV_XLEN 32

// Architectural registers including x0
`define RV_NREGS 32

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 64

// First fetch address after reset
`define RV_RESET_PC 0

`endif

/* common/rv_pkg.sv */
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_idx_t;
    typedef logic [6:0]          opcode_t;
    typedef logic [2:0]          funct3_t;
    typedef logic [6:0]          funct7_t;

    // Major opcodes of the supported subset
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        cmp_beq,
        cmp_bne,
        cmp_blt,
        cmp_bge
    } cmp_op_t;

    typedef enum logic {
        alumux2_rs2,
        alumux2_imm
    } alumux2_sel_t;

    typedef enum logic {
        wbmux_alu,
        wbmux_load
    } wbmux_sel_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t ir;
    } if_id_t;

    typedef struct packed {
        logic         valid;
        word_t        pc;
        word_t        rs1_val;
        word_t        rs2_val;
        word_t        imm;
        reg_idx_t     rd;
        alu_op_t      alu_op;
        cmp_op_t      cmp_op;
        alumux2_sel_t alumux2_sel;
        logic         is_branch;
        logic         mem_read;
        logic         mem_write;
        wbmux_sel_t   wbmux_sel;
        logic         load_regfile;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        word_t      alu_result;
        word_t      store_data;
        reg_idx_t   rd;
        logic       mem_read;
        logic       mem_write;
        wbmux_sel_t wbmux_sel;
        logic       load_regfile;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    wb_data;
        logic     load_regfile;
    } mem_wb_t;

endpackage

/* decode/rv_regfile.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_regfile (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    rs1_val,
    output rv_pkg::word_t    rs2_val,
    input  logic             we,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    wd
);
    import rv_pkg::*;

    word_t regs [`RV_NREGS];
    logic  wr_en;

    // x0 is never written
    assign wr_en = we && (rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wd;
        end
    end

    // Writeback data bypasses the array when decode reads the same register
    assign rs1_val = (wr_en && (rd == rs1)) ? wd : regs[rs1];
    assign rs2_val = (wr_en && (rd == rs2)) ? wd : regs[rs2];

endmodule

/* decode/rv_decode.sv */
`timescale 1ns/10ps

module rv_decode (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            flush,
    input  rv_pkg::if_id_t  if_id,
    input  rv_pkg::mem_wb_t wb,
    output rv_pkg::id_ex_t  id_ex
);
    import rv_pkg::*;

    opcode_t      opcode;
    funct3_t      funct3;
    funct7_t      funct7;
    word_t        imm_i;
    word_t        imm_s;
    word_t        imm_b;
    word_t        imm_u;
    word_t        rs1_val;
    word_t        rs2_val;
    logic         supported;
    word_t        imm;
    alu_op_t      alu_op;
    cmp_op_t      cmp_op;
    alumux2_sel_t alumux2_sel;
    logic         is_branch;
    logic         mem_read;
    logic         mem_write;
    logic         load_regfile;
    wbmux_sel_t   wbmux_sel;

    assign opcode = if_id.ir[6:0];
    assign funct3 = if_id.ir[14:12];
    assign funct7 = if_id.ir[31:25];

    assign imm_i = {{20{if_id.ir[31]}}, if_id.ir[31:20]};
    assign imm_s = {{20{if_id.ir[31]}}, if_id.ir[31:25], if_id.ir[11:7]};
    assign imm_b = {{19{if_id.ir[31]}}, if_id.ir[31], if_id.ir[7],
                    if_id.ir[30:25], if_id.ir[11:8], 1'b0};
    assign imm_u = {if_id.ir[31:12], 12'b0};

    rv_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs1     (if_id.ir[19:15]),
        .rs2     (if_id.ir[24:20]),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .we      (run && wb.valid && wb.load_regfile),
        .rd      (wb.rd),
        .wd      (wb.wb_data)
    );

    always_comb begin
        supported    = 1'b0;
        imm          = imm_i;
        alu_op       = alu_add;
        cmp_op       = cmp_beq;
        alumux2_sel  = alumux2_rs2;
        is_branch    = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        wbmux_sel    = wbmux_alu;
        load_regfile = 1'b0;
        case (opcode)
            op_reg: begin
                supported    = 1'b1;
                load_regfile = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = alu_add;
                    {7'b0100000, 3'b000}: alu_op = alu_sub;
                    {7'b0000000, 3'b111}: alu_op = alu_and;
                    {7'b0000000, 3'b110}: alu_op = alu_or;
                    {7'b0000000, 3'b100}: alu_op = alu_xor;
                    {7'b0000000, 3'b010}: alu_op = alu_slt;
                    {7'b0000000, 3'b001}: alu_op = alu_sll;
                    {7'b0000000, 3'b101}: alu_op = alu_srl;
                    default:              supported = 1'b0;
                endcase
            end
            op_imm: begin
                supported    = 1'b1;
                load_regfile = 1'b1;
                alumux2_sel  = alumux2_imm;
                case (funct3)
                    3'b000:  alu_op = alu_add;
                    3'b111:  alu_op = alu_and;
                    3'b110:  alu_op = alu_or;
                    3'b100:  alu_op = alu_xor;
                    3'b010:  alu_op = alu_slt;
                    default: supported = 1'b0;
                endcase
            end
            op_lui: begin
                supported    = 1'b1;
                load_regfile = 1'b1;
                imm          = imm_u;
                alumux2_sel  = alumux2_imm;
                alu_op       = alu_pass_b;
            end
            op_load: begin
                // Word loads only
                supported    = (funct3 == 3'b010);
                load_regfile = 1'b1;
                mem_read     = 1'b1;
                wbmux_sel    = wbmux_load;
                alumux2_sel  = alumux2_imm;
            end
            op_store: begin
                supported   = (funct3 == 3'b010);
                mem_write   = 1'b1;
                imm         = imm_s;
                alumux2_sel = alumux2_imm;
            end
            op_branch: begin
                supported = 1'b1;
                is_branch = 1'b1;
                imm       = imm_b;
                case (funct3)
                    3'b000:  cmp_op = cmp_beq;
                    3'b001:  cmp_op = cmp_bne;
                    3'b100:  cmp_op = cmp_blt;
                    3'b101:  cmp_op = cmp_bge;
                    default: supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= '0;
        end else if (run) begin
            id_ex.valid        <= if_id.valid && supported && !flush;
            id_ex.pc           <= if_id.pc;
            id_ex.rs1_val      <= rs1_val;
            id_ex.rs2_val      <= rs2_val;
            id_ex.imm          <= imm;
            id_ex.rd           <= if_id.ir[11:7];
            id_ex.alu_op       <= alu_op;
            id_ex.cmp_op       <= cmp_op;
            id_ex.alumux2_sel  <= alumux2_sel;
            id_ex.is_branch    <= is_branch;
            id_ex.mem_read     <= mem_read;
            id_ex.mem_write    <= mem_write;
            id_ex.wbmux_sel    <= wbmux_sel;
            id_ex.load_regfile <= load_regfile;
        end
    end

endmodule

/* hdl/rv_fetch.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_fetch (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  logic           redirect,
    input  rv_pkg::word_t  redirect_pc,
    output rv_pkg::word_t  imem_addr,
    input  rv_pkg::word_t  imem_data,
    output rv_pkg::if_id_t if_id
);
    import rv_pkg::*;

    word_t pc;
    word_t pc_next;

    // A taken branch in execute overrides sequential fetch
    assign pc_next = redirect ? redirect_pc : pc + word_t'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= word_t'(`RV_RESET_PC);
        end else if (run) begin
            pc <= pc_next;
        end
    end

    assign imem_addr = pc;

    // The word fetched this cycle is on the wrong path when execute redirects
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id <= '0;
        end else if (run) begin
            if_id.valid <= ~redirect;
            if_id.pc    <= pc;
            if_id.ir    <= imem_data;
        end
    end

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/10ps

module rv_execute (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  rv_pkg::id_ex_t  id_ex,
    output logic            redirect,
    output rv_pkg::word_t   redirect_pc,
    output rv_pkg::ex_mem_t ex_mem
);
    import rv_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_result;
    logic  taken;

    assign op_a = id_ex.rs1_val;
    assign op_b = (id_ex.alumux2_sel == alumux2_imm) ? id_ex.imm : id_ex.rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_xor: alu_result = op_a ^ op_b;
            alu_slt: alu_result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
            alu_sll: alu_result = op_a << op_b[4:0];
            alu_srl: alu_result = op_a >> op_b[4:0];
            default: alu_result = op_b;
        endcase
    end

    // Branch compare always uses both register operands
    always_comb begin
        case (id_ex.cmp_op)
            cmp_beq: taken = (id_ex.rs1_val == id_ex.rs2_val);
            cmp_bne: taken = (id_ex.rs1_val != id_ex.rs2_val);
            cmp_blt: taken = ($signed(id_ex.rs1_val) < $signed(id_ex.rs2_val));
            default: taken = ($signed(id_ex.rs1_val) >= $signed(id_ex.rs2_val));
        endcase
    end

    assign redirect    = id_ex.valid && id_ex.is_branch && taken;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else if (run) begin
            ex_mem.valid        <= id_ex.valid;
            ex_mem.alu_result   <= alu_result;
            ex_mem.store_data   <= id_ex.rs2_val;
            ex_mem.rd           <= id_ex.rd;
            ex_mem.mem_read     <= id_ex.mem_read;
            ex_mem.mem_write    <= id_ex.mem_write;
            ex_mem.wbmux_sel    <= id_ex.wbmux_sel;
            ex_mem.load_regfile <= id_ex.load_regfile;
        end
    end

endmodule

/* hdl/rv_mem_stage.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_mem_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  rv_pkg::ex_mem_t ex_mem,
    output rv_pkg::mem_wb_t mem_wb
);
    import rv_pkg::*;

    localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

    word_t              dmem [`RV_DMEM_WORDS];
    logic [dmem_aw-1:0] dmem_idx;
    word_t              load_word;
    word_t              wb_data;

    // Word address with the byte offset ignored
    assign dmem_idx = ex_mem.alu_result[dmem_aw+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (run && ex_mem.valid && ex_mem.mem_write) begin
            dmem[dmem_idx] <= ex_mem.store_data;
        end
    end

    assign load_word = ex_mem.mem_read ? dmem[dmem_idx] : '0;
    assign wb_data   = (ex_mem.wbmux_sel == wbmux_load) ? load_word : ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else if (run) begin
            mem_wb.valid        <= ex_mem.valid;
            mem_wb.rd           <= ex_mem.rd;
            mem_wb.wb_data      <= wb_data;
            mem_wb.load_regfile <= ex_mem.load_regfile;
        end
    end

endmodule

/* hdl/rv_pipe_top.sv */
`timescale 1ns/10ps

module rv_pipe_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    output rv_pkg::word_t    imem_addr,
    input  rv_pkg::word_t    imem_data,
    output logic             retire_valid,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::word_t    retire_data
);
    import rv_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic    redirect;
    word_t   redirect_pc;

    rv_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_id       (if_id)
    );

    // Redirect squashes the instruction currently in decode
    rv_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .run   (run),
        .flush (redirect),
        .if_id (if_id),
        .wb    (mem_wb),
        .id_ex (id_ex)
    );

    rv_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .id_ex       (id_ex),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    rv_mem_stage u_mem_stage (
        .clk    (clk),
        .rst    (rst),
        .run    (run),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb)
    );

    assign retire_valid = mem_wb.valid & mem_wb.load_regfile;
    assign retire_rd    = mem_wb.rd;
    assign retire_data  = mem_wb.wb_data;

endmodule

/* tb/tb_rv_pipe.sv */
`timescale 1ns/10ps

module tb_rv_pipe;

    localparam int          max_instr      = 64;
    localparam int          retire_timeout = 400;
    localparam logic [31:0] nop_ir         = 32'h0000_0013;
    localparam logic [31:0] reset_pc       = 32'h0000_0000;
    localparam logic [6:0]  opc_imm        = 7'b0010011;
    localparam logic [6:0]  opc_load       = 7'b0000011;

    logic        clk;
    logic        rst;
    logic        run;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    // Program table with each instruction word and the retirement it must produce
    logic [31:0] prog_ir  [max_instr];
    bit          prog_ret [max_instr];
    logic [4:0]  prog_rd  [max_instr];
    logic [31:0] prog_val [max_instr];
    logic [4:0]  ret_rd   [max_instr];
    logic [31:0] ret_val  [max_instr];
    int          n_instr    = 0;
    int          n_expected = 0;
    int          n_retired  = 0;
    bit          random_run = 1'b0;
    integer      seed;

    rv_pipe_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_format(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_format(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_format(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        if ($isunknown(addr)) begin
            return nop_ir;
        end
        idx = int'(addr >> 2);
        if (idx < n_instr) begin
            return prog_ir[idx];
        end
        return nop_ir;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time=%0t signal=%s got=0x%08h expected=0x%08h",
                                $time, name, got, exp));
        end
    endtask

    task automatic append_instr(input logic [31:0] ir, input bit ret, input logic [4:0] rd,
                                input logic [31:0] val);
        prog_ir[n_instr]  = ir;
        prog_ret[n_instr] = ret;
        prog_rd[n_instr]  = rd;
        prog_val[n_instr] = val;
        n_instr++;
    endtask

    // Dependent instructions sit at least three slots after their producer
    task automatic build_program();
        append_instr(i_format(opc_imm, 3'b000, 5'd1, 5'd0, 12'd100), 1, 5'd1, 32'd100);
        append_instr(i_format(opc_imm, 3'b000, 5'd2, 5'd0, 12'hff9), 1, 5'd2, 32'hffff_fff9);
        append_instr(i_format(opc_imm, 3'b000, 5'd3, 5'd0, 12'h5a5), 1, 5'd3, 32'h5a5);
        append_instr(i_format(opc_imm, 3'b000, 5'd4, 5'd0, 12'd3), 1, 5'd4, 32'd3);
        append_instr(i_format(opc_imm, 3'b000, 5'd5, 5'd0, 12'h0f0), 1, 5'd5, 32'h0f0);
        append_instr(r_format(7'b0000000, 3'b000, 5'd6, 5'd1, 5'd2), 1, 5'd6, 32'd93);
        append_instr(r_format(7'b0100000, 3'b000, 5'd7, 5'd3, 5'd1), 1, 5'd7, 32'h541);
        append_instr(r_format(7'b0000000, 3'b111, 5'd8, 5'd3, 5'd5), 1, 5'd8, 32'h0a0);
        append_instr(r_format(7'b0000000, 3'b110, 5'd9, 5'd3, 5'd5), 1, 5'd9, 32'h5f5);
        append_instr(r_format(7'b0000000, 3'b100, 5'd10, 5'd3, 5'd5), 1, 5'd10, 32'h555);
        append_instr(r_format(7'b0000000, 3'b010, 5'd11, 5'd2, 5'd1), 1, 5'd11, 32'd1);
        append_instr(r_format(7'b0000000, 3'b001, 5'd12, 5'd1, 5'd4), 1, 5'd12, 32'h320);
        append_instr(r_format(7'b0000000, 3'b101, 5'd13, 5'd2, 5'd4), 1, 5'd13, 32'h1fff_ffff);
        // x0 target still retires its value
        append_instr(i_format(opc_imm, 3'b000, 5'd0, 5'd1, 12'd5), 1, 5'd0, 32'd105);
        append_instr(i_format(opc_imm, 3'b010, 5'd14, 5'd2, 12'd0), 1, 5'd14, 32'd1);
        append_instr(i_format(opc_imm, 3'b100, 5'd15, 5'd1, 12'h0ff), 1, 5'd15, 32'h09b);
        append_instr(r_format(7'b0000000, 3'b000, 5'd16, 5'd0, 5'd1), 1, 5'd16, 32'd100);
        append_instr(i_format(opc_imm, 3'b111, 5'd17, 5'd3, 12'h0ff), 1, 5'd17, 32'h0a5);
        append_instr(i_format(opc_imm, 3'b110, 5'd18, 5'd4, 12'h100), 1, 5'd18, 32'h103);
        append_instr(s_format(5'd6, 5'd0, 12'd8), 0, 5'd0, 32'd0);
        append_instr(s_format(5'd9, 5'd0, 12'd20), 0, 5'd0, 32'd0);
        append_instr(i_format(opc_load, 3'b010, 5'd19, 5'd0, 12'd8), 1, 5'd19, 32'd93);
        append_instr(i_format(opc_load, 3'b010, 5'd20, 5'd0, 12'd20), 1, 5'd20, 32'h5f5);
        append_instr(i_format(opc_load, 3'b010, 5'd21, 5'd0, 12'd40), 1, 5'd21, 32'd0);
        // Taken beq skips the next two entries on the wrong path
        append_instr(b_format(3'b000, 5'd1, 5'd16, 13'd12), 0, 5'd0, 32'd0);
        append_instr(i_format(opc_imm, 3'b000, 5'd22, 5'd0, 12'd1), 0, 5'd22, 32'd1);
        append_instr(i_format(opc_imm, 3'b000, 5'd23, 5'd0, 12'd2), 0, 5'd23, 32'd2);
        append_instr(b_format(3'b001, 5'd1, 5'd16, 13'd12), 0, 5'd0, 32'd0);
        append_instr(i_format(opc_imm, 3'b000, 5'd24, 5'd0, 12'd33), 1, 5'd24, 32'd33);
        append_instr(b_format(3'b100, 5'd2, 5'd1, 13'd12), 0, 5'd0, 32'd0);
        append_instr(i_format(opc_imm, 3'b000, 5'd25, 5'd0, 12'd3), 0, 5'd25, 32'd3);
        append_instr(i_format(opc_imm, 3'b000, 5'd26, 5'd0, 12'd4), 0, 5'd26, 32'd4);
        append_instr(b_format(3'b101, 5'd2, 5'd1, 13'd12), 0, 5'd0, 32'd0);
        append_instr(i_format(opc_imm, 3'b000, 5'd27, 5'd0, 12'd44), 1, 5'd27, 32'd44);
        append_instr(u_format(5'd28, 20'habcde), 1, 5'd28, 32'habcd_e000);
        append_instr(u_format(5'd29, 20'h80001), 1, 5'd29, 32'h8000_1000);
        for (int i = 0; i < n_instr; i++) begin
            if (prog_ret[i]) begin
                ret_rd[n_expected]  = prog_rd[i];
                ret_val[n_expected] = prog_val[i];
                n_expected++;
            end
        end
    endtask

    // Instruction port follows the registered PC and run may drop on random cycles
    initial begin
        seed      = 6677;
        run       = 1'b0;
        imem_data = nop_ir;
        forever begin
            @(posedge clk);
            #1;
            imem_data = fetch_word(imem_addr);
            if (random_run) begin
                run = (($random(seed) & 3) != 0);
            end else begin
                run = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            n_retired = 0;
        end else if (run && retire_valid) begin
            if (n_retired < n_expected) begin
                check_value("retire_rd", 32'(retire_rd), 32'(ret_rd[n_retired]));
                check_value("retire_data", retire_data, ret_val[n_retired]);
            end else begin
                // Past the table end only NOPs arrive
                check_value("retire_rd", 32'(retire_rd), 32'd0);
                check_value("retire_data", retire_data, 32'd0);
            end
            n_retired++;
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // First fetch after reset comes from the reset vector
        check_value("imem_addr", imem_addr, reset_pc);
    endtask

    task automatic wait_for_retirements();
        int cycles;
        cycles = 0;
        while (n_retired < n_expected) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > retire_timeout) begin
                abort_run("Timed out waiting for the program to retire");
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        build_program();
        for (int pass = 0; pass < 2; pass++) begin
            random_run = (pass == 1);
            apply_reset();
            wait_for_retirements();
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/rv_pkg.sv
decode/rv_regfile.sv
decode/rv_decode.sv
hdl/rv_fetch.sv
hdl/rv_execute.sv
hdl/rv_mem_stage.sv
hdl/rv_pipe_top.sv
tb/tb_rv_pipe.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the run from its log
verilator --binary --timing --top-module tb_rv_pipe -f files.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
